// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // datapath and address width
  localparam int unsigned xlen = 32;

  // register index width and count
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned num_regs = 32;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // sequential pc step, one 32-bit word
  localparam logic [xlen-1:0] inst_step = 32'd4;

  // major opcodes handled by the core
  // anything else retires as a no-op
  typedef enum logic [6:0] {
    op_imm    = 7'b001_0011,
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_system = 7'b111_0011
  } opcode_e;

  // funct3 of addi inside op_imm
  localparam logic [2:0] funct3_addi = 3'b000;

  // full ebreak word, compared as a whole
  localparam logic [xlen-1:0] ebreak_inst = 32'h0010_0073;

  // first adder operand
  typedef enum logic {
    op_a_rs1 = 1'b0,
    op_a_pc  = 1'b1
  } op_a_sel_e;

  // writeback source
  // link is pc plus 4 for jal and jalr
  typedef enum logic {
    wb_sum  = 1'b0,
    wb_link = 1'b1
  } wb_sel_e;

  // next pc source
  typedef enum logic [1:0] {
    pc_seq    = 2'b00,
    pc_target = 2'b01,
    // jalr target, bit 0 forced low
    pc_jalr   = 2'b10
  } pc_sel_e;

endpackage

`default_nettype wire

// File: source/rv_decoder.sv
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  wire logic [xlen-1:0]       inst,
  output logic      [reg_addr_w-1:0] rs1,
  output logic      [reg_addr_w-1:0] rd,
  output logic      [xlen-1:0]       imm,
  output op_a_sel_e                  op_a_sel,
  output wb_sel_e                    wb_sel,
  output pc_sel_e                    pc_sel,
  output logic                       reg_write,
  output logic                       is_ebreak
);

  // raw instruction fields
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [reg_addr_w-1:0] rs1_field;

  // sign-extended immediates
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign opcode    = opcode_e'(inst[6:0]);
  assign funct3    = inst[14:12];
  assign rs1_field = inst[19:15];
  assign rd        = inst[11:7];

  // i-type, 12 bits from the top
  assign imm_i = {{20{inst[31]}}, inst[31:20]};

  // u-type, upper 20 bits, low bits zero
  assign imm_u = {inst[31:12], 12'h000};

  // j-type, scrambled offset, always even
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // ebreak is matched on the whole word
  assign is_ebreak = (inst == ebreak_inst);

  always_comb begin
    // defaults describe a no-op
    rs1       = rs1_field;
    imm       = imm_i;
    op_a_sel  = op_a_rs1;
    wb_sel    = wb_sum;
    pc_sel    = pc_seq;
    reg_write = 1'b0;

    case (opcode)
      op_imm: begin
        // only addi is kept, other funct3 values drop through
        if (funct3 == funct3_addi) begin
          reg_write = 1'b1;
        end
      end
      op_lui: begin
        // x0 plus imm gives the immediate itself
        rs1       = '0;
        imm       = imm_u;
        reg_write = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        op_a_sel  = op_a_pc;
        reg_write = 1'b1;
      end
      op_jal: begin
        imm       = imm_j;
        op_a_sel  = op_a_pc;
        wb_sel    = wb_link;
        pc_sel    = pc_target;
        reg_write = 1'b1;
      end
      op_jalr: begin
        // rs1 plus imm_i, low bit cleared later
        wb_sel    = wb_link;
        pc_sel    = pc_jalr;
        reg_write = 1'b1;
      end
      op_system: begin
        // ebreak handled by is_ebreak, nothing written
        reg_write = 1'b0;
      end
      default: begin
        // unknown opcode, pc plus 4 only
        reg_write = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic [reg_addr_w-1:0] raddr,
  output logic      [xlen-1:0]       rdata,
  input  wire logic                  wen,
  input  wire logic [reg_addr_w-1:0] waddr,
  input  wire logic [xlen-1:0]       wdata
);

  // x1 to x31 only, x0 has no storage
  logic [xlen-1:0] regs [1:num_regs-1];

  // combinational read
  // x0 reads as zero
  always_comb begin
    if (raddr == '0) begin
      rdata = '0;
    end else begin
      rdata = regs[raddr];
    end
  end

  // write at the rising edge
  always_ff @(posedge clk) begin
    if (reset) begin
      // whole file starts at zero
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: source/rv_execute.sv
`default_nettype none

module rv_execute import rv_pkg::*; (
  input  wire logic [xlen-1:0] pc,
  input  wire logic [xlen-1:0] rs1_data,
  input  wire logic [xlen-1:0] imm,
  input  wire op_a_sel_e       op_a_sel,
  input  wire wb_sel_e         wb_sel,
  input  wire pc_sel_e         pc_sel,
  output logic      [xlen-1:0] next_pc,
  output logic      [xlen-1:0] wb_data
);

  // adder operands and result
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] sum;

  // address of the following instruction
  logic [xlen-1:0] seq_pc;

  // first operand, register or pc
  always_comb begin
    case (op_a_sel)
      op_a_pc:  op_a = pc;
      default:  op_a = rs1_data;
    endcase
  end

  // one adder serves addi, lui, auipc and both jumps
  assign sum = op_a + imm;

  // link value and fall-through pc
  assign seq_pc = pc + inst_step;

  // next pc
  always_comb begin
    case (pc_sel)
      pc_target: next_pc = sum;
      // jalr target must be even
      pc_jalr:   next_pc = {sum[xlen-1:1], 1'b0};
      default:   next_pc = seq_pc;
    endcase
  end

  // writeback data
  always_comb begin
    case (wb_sel)
      wb_link: wb_data = seq_pc;
      default: wb_data = sum;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_pc_unit.sv
`default_nettype none

module rv_pc_unit import rv_pkg::*; (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic [xlen-1:0] next_pc,
  input  wire logic            is_ebreak,
  output logic      [xlen-1:0] pc,
  output logic                 halted,
  output logic                 retire_en
);

  // one instruction retires per cycle until halt
  // nothing retires while reset is high
  assign retire_en = !halted && !reset;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= reset_pc;
      halted <= 1'b0;
    end else if (retire_en) begin
      if (is_ebreak) begin
        // stop here, pc stays on the ebreak
        halted <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic [xlen-1:0]       inst,
  output logic      [xlen-1:0]       pc,
  output logic                       commit_valid,
  output logic      [reg_addr_w-1:0] commit_rd,
  output logic      [xlen-1:0]       commit_data,
  output logic                       halted
);

  // decode outputs
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       imm;
  op_a_sel_e             op_a_sel;
  wb_sel_e               wb_sel;
  pc_sel_e               pc_sel;
  logic                  reg_write;
  logic                  is_ebreak;

  // register read
  logic [xlen-1:0] rs1_data;

  // execute outputs
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] wb_data;

  // retirement gate from the pc unit
  logic retire_en;

  // qualified write, never for x0
  // also the commit strobe
  assign commit_valid = retire_en && reg_write && (rd != '0);
  assign commit_rd    = rd;
  assign commit_data  = wb_data;

  rv_decoder u_decoder (
    .inst      (inst),
    .rs1       (rs1),
    .rd        (rd),
    .imm       (imm),
    .op_a_sel  (op_a_sel),
    .wb_sel    (wb_sel),
    .pc_sel    (pc_sel),
    .reg_write (reg_write),
    .is_ebreak (is_ebreak)
  );

  rv_regfile u_regfile (
    .clk   (clk),
    .reset (reset),
    .raddr (rs1),
    .rdata (rs1_data),
    .wen   (commit_valid),
    .waddr (rd),
    .wdata (wb_data)
  );

  rv_execute u_execute (
    .pc       (pc),
    .rs1_data (rs1_data),
    .imm      (imm),
    .op_a_sel (op_a_sel),
    .wb_sel   (wb_sel),
    .pc_sel   (pc_sel),
    .next_pc  (next_pc),
    .wb_data  (wb_data)
  );

  rv_pc_unit u_pc_unit (
    .clk       (clk),
    .reset     (reset),
    .next_pc   (next_pc),
    .is_ebreak (is_ebreak),
    .pc        (pc),
    .halted    (halted),
    .retire_en (retire_en)
  );

endmodule

`default_nettype wire

// File: dv/rv_core_tb.sv
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // run length and timing
  localparam int num_insts    = 400;
  localparam int idle_insts   = 5;
  localparam int reset_cycles = 4;
  localparam int clk_period   = 8;
  // commit outputs sampled this long after the falling edge
  localparam int sample_delay = 2;
  localparam int timeout_ns   = (num_insts + 20) * clk_period + reset_cycles * clk_period;

  logic                  clk;
  logic                  reset;
  logic [xlen-1:0]       inst;
  logic [xlen-1:0]       pc;
  logic                  commit_valid;
  logic [reg_addr_w-1:0] commit_rd;
  logic [xlen-1:0]       commit_data;
  logic                  halted;

  // reference model state
  logic [xlen-1:0] model_regs [0:num_regs-1];
  logic [xlen-1:0] model_pc;
  logic            model_halted;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;

  rv_core u_dut (
    .clk          (clk),
    .reset        (reset),
    .inst         (inst),
    .pc           (pc),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .halted       (halted)
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  // pick a kind, then rd, rs1 and the immediate
  task automatic random_inst(output logic [31:0] word, output string kind);
    logic [31:0] sel;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] imm;
    logic [31:0] f3;
    logic [31:0] opc;
    logic [6:0]  opcode;
    draw_bits(3, sel);
    draw_bits(5, rd);
    draw_bits(5, rs1);
    case (sel[2:0])
      3'd0, 3'd7: begin
        draw_bits(12, imm);
        word = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b001_0011};
        kind = "addi";
      end
      3'd1: begin
        draw_bits(20, imm);
        word = {imm[19:0], rd[4:0], 7'b011_0111};
        kind = "lui";
      end
      3'd2: begin
        draw_bits(20, imm);
        word = {imm[19:0], rd[4:0], 7'b001_0111};
        kind = "auipc";
      end
      3'd3: begin
        // raw j-type bits, the scramble is undone by the model
        draw_bits(20, imm);
        word = {imm[19:0], rd[4:0], 7'b110_1111};
        kind = "jal";
      end
      3'd4: begin
        draw_bits(12, imm);
        word = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b110_0111};
        kind = "jalr";
      end
      3'd5: begin
        // load, store, branch or reg-reg op, none of them kept
        draw_bits(2, opc);
        draw_bits(20, imm);
        case (opc[1:0])
          2'd0:    opcode = 7'b000_0011;
          2'd1:    opcode = 7'b010_0011;
          2'd2:    opcode = 7'b110_0011;
          default: opcode = 7'b011_0011;
        endcase
        word = {imm[19:0], rd[4:0], opcode};
        kind = "unknown";
      end
      default: begin
        // op_imm but not addi
        draw_bits(3, f3);
        if (f3[2:0] == 3'd0) begin
          f3 = 32'd7;
        end
        draw_bits(12, imm);
        word = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b001_0011};
        kind = "op_imm_other";
      end
    endcase
  endtask

  // expected commit and next pc from the model state
  task automatic predict(input logic [31:0] word, output logic wr, output logic [31:0] wdata,
                         output logic [31:0] npc, output logic halt_now);
    logic [31:0] src;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    src   = model_regs[word[19:15]];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_u = {word[31:12], 12'h000};
    imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    wr       = 1'b0;
    wdata    = '0;
    npc      = model_pc + 32'd4;
    halt_now = 1'b0;
    if (model_halted) begin
      // frozen until reset
      npc = model_pc;
    end else if (word == ebreak_inst) begin
      npc      = model_pc;
      halt_now = 1'b1;
    end else begin
      case (word[6:0])
        7'b001_0011: begin
          if (word[14:12] == 3'b000) begin
            wr    = 1'b1;
            wdata = src + imm_i;
          end
        end
        7'b011_0111: begin
          wr    = 1'b1;
          wdata = imm_u;
        end
        7'b001_0111: begin
          wr    = 1'b1;
          wdata = model_pc + imm_u;
        end
        7'b110_1111: begin
          wr    = 1'b1;
          wdata = model_pc + 32'd4;
          npc   = model_pc + imm_j;
        end
        7'b110_0111: begin
          wr    = 1'b1;
          wdata = model_pc + 32'd4;
          // target read before rd is written, low bit cleared
          npc   = (src + imm_i) & ~32'd1;
        end
        default: begin
          wr = 1'b0;
        end
      endcase
    end
    // x0 never commits
    if (word[11:7] == 5'd0) begin
      wr = 1'b0;
    end
  endtask

  // called on a falling edge, returns on the next one
  task automatic run_inst(input logic [31:0] word, input string kind, input int idx);
    logic        wr;
    logic [31:0] wdata;
    logic [31:0] npc;
    logic        halt_now;
    string       tag;
    tag = $sformatf("inst %0d %s", idx, kind);
    // state left by the previous rising edge
    check_value({tag, " pc"}, model_pc, pc);
    check_value({tag, " halted"}, 32'(model_halted), 32'(halted));
    inst = word;
    #(sample_delay);
    predict(word, wr, wdata, npc, halt_now);
    check_value({tag, " commit_valid"}, 32'(wr), 32'(commit_valid));
    if (wr) begin
      check_value({tag, " commit_rd"}, 32'(word[11:7]), 32'(commit_rd));
      check_value({tag, " commit_data"}, wdata, commit_data);
      model_regs[word[11:7]] = wdata;
    end
    model_pc = npc;
    if (halt_now) begin
      model_halted = 1'b1;
    end
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] word;
    string       kind;
    int          idx;
    errors     = 0;
    checks     = 0;
    idx        = 0;
    lfsr_state = 32'h55df_5df9;
    reset      = 1'b1;
    // addi x5, x0, 1 held during reset, must not commit
    inst       = {12'd1, 5'd0, 3'b000, 5'd5, 7'b001_0011};
    for (int i = 0; i < num_regs; i++) begin
      model_regs[i] = '0;
    end
    model_pc     = reset_pc;
    model_halted = 1'b0;

    repeat (reset_cycles) begin
      @(negedge clk);
      check_value("reset pc", reset_pc, pc);
      check_value("reset halted", 32'd0, 32'(halted));
      check_value("reset commit_valid", 32'd0, 32'(commit_valid));
    end
    reset = 1'b0;

    // random program
    for (int i = 0; i < num_insts; i++) begin
      random_inst(word, kind);
      run_inst(word, kind, idx);
      idx++;
    end

    // addi x0, x7, 0x7ff then addi x1, x0, 0x05a
    run_inst({12'h7ff, 5'd7, 3'b000, 5'd0, 7'b001_0011}, "addi_to_x0", idx);
    idx++;
    run_inst({12'h05a, 5'd0, 3'b000, 5'd1, 7'b001_0011}, "read_x0", idx);
    idx++;

    run_inst(ebreak_inst, "ebreak", idx);
    idx++;

    // everything after the halt is ignored
    repeat (idle_insts) begin
      random_inst(word, kind);
      run_inst(word, {"halted ", kind}, idx);
      idx++;
    end
    check_value("final pc", model_pc, pc);
    check_value("final halted", 32'd1, 32'(halted));

    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeout_ns);
    $display("watchdog timeout: the run did not end within %0d ns", timeout_ns);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_pc_unit.sv
source/rv_core.sv
dv/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

sim_log=sim.log

echo "building..."
verilator --binary --timing -j 0 \
  --top-module rv_core_tb \
  -f sim.f \
  -Mdir obj_dir \
  -o rv_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

echo "running..."
./obj_dir/rv_core_sim > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$sim_log"; then
  exit 1
fi
exit 0
